/* source/mulMacros.svh */
/*
 Multiply unit widths and fast divide limits
*/

`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand and result widths fixed by the core
`define MUL_WORD_WIDTH 32
`define MUL_DWORD_WIDTH 64

// split point of the partial product array
`define MUL_HALF_WIDTH 16

// fast divide takes divisors up to this value
`define MUL_DIV_MAX 63
// dividend must stay below this bit
`define MUL_DIV_DIVIDEND_BITS 30

// reciprocal table index and shift code widths
`define MUL_RCP_INDEX_BITS 5
`define MUL_DIV_SHIFT_BITS 3

`endif

/* source/mulDataPkg.sv */
/*
 Multiply unit data types
 Operand, product and fast divide field widths
*/

`include "mulMacros.svh"

package mulDataPkg;

	// single operand as it comes from the register file
	typedef logic [`MUL_WORD_WIDTH-1:0] word_t;

	// full product, accumulator and result
	typedef logic [`MUL_DWORD_WIDTH-1:0] dword_t;

	// selects a reciprocal by the divisor's odd part
	typedef logic [`MUL_RCP_INDEX_BITS-1:0] rcpIndex_t;

	// post-multiply shift for the fast divide
	// quotient is taken from 30 + code bits up
	typedef logic [`MUL_DIV_SHIFT_BITS-1:0] divShift_t;

endpackage

/* source/mulCmdPkg.sv */
/*
 Multiply unit commands
 Operation codes and the control word carried down the pipeline
*/

package mulCmdPkg;

	import mulDataPkg::*;

	// operation code from the decode stage
	typedef enum logic [2:0] {
		mulS32 = 3'd0,
		mulU32 = 3'd1,
		mulS64 = 3'd2,
		mulU64 = 3'd3,
		macS64 = 3'd4,
		divS   = 3'd5,
		divU   = 3'd6
	} mulOp_t;

	// decoded control, travels alongside the operands
	typedef struct packed {
		logic      isUnsigned;
		logic      keepHigh;
		logic      accumulate;
		logic      isDiv;
		logic      divFast;
		divShift_t divShift;
	} mulCtl_t;

endpackage

/* source/mulOperandPrep.sv */
/*
 Multiply operand preparation
 Decodes the operation and swaps a small divisor for its reciprocal
*/

`include "mulMacros.svh"

module mulOperandPrep
	import mulDataPkg::*, mulCmdPkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    issue,
	input  logic    hold,
	input  mulOp_t  op,
	input  word_t   operandA,
	input  word_t   operandB,
	input  dword_t  accum,
	output word_t   effA,
	output word_t   effB,
	output dword_t  accAdd,
	output mulCtl_t ctl,
	output logic    prepValid
);

	// rounded-up 2^k / odd, indexed by odd part >> 1
	localparam word_t rcpTable [0:31] = '{
		32'h40000000, 32'h55555556, 32'h66666667, 32'h4924924A,
		32'h71C71C72, 32'h5D1745D2, 32'h4EC4EC4F, 32'h44444445,
		32'h78787879, 32'h6BCA1AF3, 32'h61861862, 32'h590B2165,
		32'h51EB851F, 32'h4BDA12F7, 32'h469EE585, 32'h42108422,
		32'h7C1F07C2, 32'h75075076, 32'h6EB3E454, 32'h6906906A,
		32'h63E7063F, 32'h5F417D06, 32'h5B05B05C, 32'h572620AF,
		32'h5397829D, 32'h50505051, 32'h4D4873ED, 32'h4A7904A8,
		32'h47DC11F8, 32'h456C797E, 32'h4325C53F, 32'h41041042
	};

	// shift code per divisor, ceil of log2
	localparam divShift_t shiftTable [0:63] = '{
		3'd0, 3'd0, 3'd1, 3'd2, 3'd2, 3'd3, 3'd3, 3'd3,
		3'd3, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4,
		3'd4, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5,
		3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5,
		3'd5, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6,
		3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6,
		3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6,
		3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6
	};

	mulCtl_t   decCtl;
	logic      divInRange;
	logic [5:0] divOdd;
	rcpIndex_t rcpIndex;
	word_t     rcpValue;

	// strip trailing zeros, a divisor of 63 or less has at most five
	always_comb begin
		divOdd = operandB[5:0];
		for (int i = 0; i < 5; i++) begin
			if (!divOdd[0])
				divOdd = divOdd >> 1;
		end
	end

	assign rcpIndex = divOdd[5:1];
	assign rcpValue = rcpTable[rcpIndex];

	assign divInRange = (operandB >= 2) && (operandB <= `MUL_DIV_MAX) &&
		(operandA[`MUL_WORD_WIDTH-1:`MUL_DIV_DIVIDEND_BITS] == '0);

	always_comb begin
		decCtl = '0;
		case (op)
			mulU32: decCtl.isUnsigned = 1'b1;
			mulS64: decCtl.keepHigh = 1'b1;
			mulU64: begin
				decCtl.isUnsigned = 1'b1;
				decCtl.keepHigh = 1'b1;
			end
			macS64: begin
				decCtl.keepHigh = 1'b1;
				decCtl.accumulate = 1'b1;
			end
			divS: decCtl.isDiv = 1'b1;
			divU: begin
				decCtl.isDiv = 1'b1;
				decCtl.isUnsigned = 1'b1;
			end
			// mulS32 and unused codes need no bits
			default: ;
		endcase
		decCtl.divFast = decCtl.isDiv && divInRange;
		if (decCtl.divFast)
			decCtl.divShift = shiftTable[operandB[5:0]];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			prepValid <= 1'b0;
			ctl <= '0;
		end else if (!hold) begin
			prepValid <= issue;
			ctl <= decCtl;
		end
	end

	// operand registers, divisor replaced by its reciprocal
	always_ff @(posedge clock) begin
		if (!hold) begin
			effA <= operandA;
			effB <= decCtl.divFast ? rcpValue : operandB;
			accAdd <= decCtl.accumulate ? accum : '0;
		end
	end

endmodule

/* source/mulPartialArray.sv */
/*
 Multiply partial product array
 Stage one 16x16 products, stage two carry-save merge with accumulator
*/

`include "mulMacros.svh"

module mulPartialArray
	import mulDataPkg::*, mulCmdPkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    hold,
	input  word_t   effA,
	input  word_t   effB,
	input  dword_t  accAdd,
	input  mulCtl_t ctl,
	input  logic    prepValid,
	output dword_t  partLow,
	output dword_t  partHigh,
	output dword_t  crossSum,
	output mulCtl_t ctl2,
	output logic    valid2
);

	logic [`MUL_HALF_WIDTH-1:0] aLow;
	logic [`MUL_HALF_WIDTH-1:0] aHigh;
	logic [`MUL_HALF_WIDTH-1:0] bLow;
	logic [`MUL_HALF_WIDTH-1:0] bHigh;
	logic [`MUL_HALF_WIDTH-1:0] aExt;
	logic [`MUL_HALF_WIDTH-1:0] bExt;
	logic [`MUL_HALF_WIDTH-1:0] corrNext;

	word_t   mulLL;
	word_t   mulLH;
	word_t   mulHL;
	word_t   mulHH;
	logic [`MUL_HALF_WIDTH-1:0] corr1;
	dword_t  acc1;
	mulCtl_t ctl1;
	logic    valid1;

	dword_t  crossA;
	dword_t  crossB;
	dword_t  csSum;
	dword_t  csCarry;
	word_t   highWord;

	assign aLow = effA[`MUL_HALF_WIDTH-1:0];
	assign aHigh = effA[`MUL_WORD_WIDTH-1:`MUL_HALF_WIDTH];
	assign bLow = effB[`MUL_HALF_WIDTH-1:0];
	assign bHigh = effB[`MUL_WORD_WIDTH-1:`MUL_HALF_WIDTH];

	// upper halves are signed unless the op is unsigned
	assign aExt = (effA[`MUL_WORD_WIDTH-1] && !ctl.isUnsigned) ? '1 : '0;
	assign bExt = (effB[`MUL_WORD_WIDTH-1] && !ctl.isUnsigned) ? '1 : '0;

	// high x high is done unsigned, this puts the sign weight back
	assign corrNext = (aExt & -bHigh) + (bExt & -aHigh);

	always_ff @(posedge clock) begin
		if (!hold) begin
			mulLL <= aLow * bLow;
			mulLH <= {16'h0000, aLow} * {bExt, bHigh};
			mulHL <= {aExt, aHigh} * {16'h0000, bLow};
			mulHH <= aHigh * bHigh;
			corr1 <= corrNext;
			acc1 <= accAdd;
		end
	end

	// cross products land at bit 16, sign-extended when signed
	assign crossA = {{16{mulLH[31] && !ctl1.isUnsigned}}, mulLH, 16'h0000};
	assign crossB = {{16{mulHL[31] && !ctl1.isUnsigned}}, mulHL, 16'h0000};

	// 3:2 compress of both cross terms and the accumulator
	assign csSum = crossA ^ crossB ^ acc1;
	assign csCarry = ((crossA & crossB) | (crossA & acc1) | (crossB & acc1)) << 1;

	assign highWord = mulHH + {corr1, 16'h0000};

	always_ff @(posedge clock) begin
		if (!hold) begin
			partLow <= {32'h0000_0000, mulLL};
			partHigh <= {highWord, 32'h0000_0000};
			crossSum <= csSum + csCarry;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			ctl1 <= '0;
			ctl2 <= '0;
		end else if (!hold) begin
			valid1 <= prepValid;
			valid2 <= valid1;
			ctl1 <= ctl;
			ctl2 <= ctl1;
		end
	end

endmodule

/* source/mulResultShaper.sv */
/*
 Multiply result shaping
 Final add, width and sign shaping, divide shift and output register
*/

`include "mulMacros.svh"

module mulResultShaper
	import mulDataPkg::*, mulCmdPkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    hold,
	input  dword_t  partLow,
	input  dword_t  partHigh,
	input  dword_t  crossSum,
	input  mulCtl_t ctl2,
	input  logic    valid2,
	output dword_t  result,
	output logic    resultValid,
	output logic    divFast
);

	dword_t product;
	dword_t divQuot;
	dword_t shaped;

	assign product = partLow + partHigh + crossSum;

	// quotient sits 30 + shift code bits up in the product
	assign divQuot = product >> (`MUL_DIV_DIVIDEND_BITS + ctl2.divShift);

	always_comb begin
		shaped = product;
		// 32-bit ops keep the low word, extended by signedness
		if (!ctl2.keepHigh)
			shaped[`MUL_DWORD_WIDTH-1:`MUL_WORD_WIDTH] =
				{`MUL_WORD_WIDTH{product[`MUL_WORD_WIDTH-1] && !ctl2.isUnsigned}};
		if (ctl2.isDiv) begin
			if (ctl2.divFast)
				shaped = {32'h0000_0000, divQuot[`MUL_WORD_WIDTH-1:0]};
			else
				shaped = '0;   // slow path not present
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
			resultValid <= 1'b0;
			divFast <= 1'b0;
		end else if (!hold) begin
			resultValid <= valid2;
			divFast <= valid2 && ctl2.divFast;
			// last result stays put between operations
			if (valid2)
				result <= shaped;
		end
	end

endmodule

/* source/mulUnit.sv */
/*
 Pipelined integer multiply unit
 Three-stage multiply, multiply-accumulate and reciprocal divide
*/

module mulUnit
	import mulDataPkg::*, mulCmdPkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   issue,
	input  mulOp_t op,
	input  word_t  operandA,
	input  word_t  operandB,
	input  dword_t accum,
	input  logic   hold,
	output dword_t result,
	output logic   resultValid,
	output logic   divFast
);

	// prep to array
	word_t   effA;
	word_t   effB;
	dword_t  accAdd;
	mulCtl_t ctl;
	logic    prepValid;

	// array to shaper
	dword_t  partLow;
	dword_t  partHigh;
	dword_t  crossSum;
	mulCtl_t ctl2;
	logic    valid2;

	mulOperandPrep prep0 (
		.clock     (clock),
		.reset     (reset),
		.issue     (issue),
		.hold      (hold),
		.op        (op),
		.operandA  (operandA),
		.operandB  (operandB),
		.accum     (accum),
		.effA      (effA),
		.effB      (effB),
		.accAdd    (accAdd),
		.ctl       (ctl),
		.prepValid (prepValid)
	);

	mulPartialArray array0 (
		.clock     (clock),
		.reset     (reset),
		.hold      (hold),
		.effA      (effA),
		.effB      (effB),
		.accAdd    (accAdd),
		.ctl       (ctl),
		.prepValid (prepValid),
		.partLow   (partLow),
		.partHigh  (partHigh),
		.crossSum  (crossSum),
		.ctl2      (ctl2),
		.valid2    (valid2)
	);

	mulResultShaper shaper0 (
		.clock       (clock),
		.reset       (reset),
		.hold        (hold),
		.partLow     (partLow),
		.partHigh    (partHigh),
		.crossSum    (crossSum),
		.ctl2        (ctl2),
		.valid2      (valid2),
		.result      (result),
		.resultValid (resultValid),
		.divFast     (divFast)
	);

endmodule

/* test/mulUnit_chk.sv */
/*
 Multiply unit pipeline checks
 Bound to the top level, watches valid timing and hold behavior
*/

module mulUnitChk
	import mulDataPkg::*;
(
	input logic   clock,
	input logic   reset,
	input logic   issue,
	input logic   hold,
	input dword_t result,
	input logic   resultValid,
	input logic   divFast
);

	int failCount = 0;

	// issue strobes carried along the unheld edges
	logic [3:0] issueTrail;

	always_ff @(posedge clock) begin
		if (reset)
			issueTrail <= '0;
		else if (!hold)
			issueTrail <= {issueTrail[2:0], issue};
	end

	assert property (@(posedge clock) reset |=> !resultValid)
		else begin
			failCount++;
			$error("resultValid high right after reset");
		end

	assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable(result) && $stable(resultValid))
		else begin
			failCount++;
			$error("output moved while hold was high");
		end

	assert property (@(posedge clock) disable iff (reset) divFast |-> resultValid)
		else begin
			failCount++;
			$error("divFast high without resultValid");
		end

	// three unheld edges after the issue edge
	assert property (@(posedge clock) disable iff (reset) resultValid == issueTrail[3])
		else begin
			failCount++;
			$error("resultValid out of step with issue");
		end

endmodule

bind mulUnit mulUnitChk chk0 (
	.clock       (clock),
	.reset       (reset),
	.issue       (issue),
	.hold        (hold),
	.result      (result),
	.resultValid (resultValid),
	.divFast     (divFast)
);

/* test/mulUnitTb.sv */
/*
 Multiply unit testbench
 Vector table issued under random hold, results checked in issue order
*/

module mulUnitTb
	import mulDataPkg::*, mulCmdPkg::*;
();

	localparam int maxVectors = 40;

	logic   clock;
	logic   reset;
	logic   issue;
	mulOp_t op;
	word_t  operandA;
	word_t  operandB;
	dword_t accum;
	logic   hold;
	dword_t result;
	logic   resultValid;
	logic   divFast;

	// vector table
	string  vecName [maxVectors];
	mulOp_t vecOp [maxVectors];
	word_t  vecA [maxVectors];
	word_t  vecB [maxVectors];
	dword_t vecAcc [maxVectors];
	dword_t vecExp [maxVectors];
	logic   vecFast [maxVectors];
	int     numVectors = 0;

	// rows issued and still in flight
	int pending [$];
	logic [31:0] lfsrState = 32'h24c0;
	int cycleCount = 0;
	int cycleLimit = 0;

	mulUnit dut0 (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.op          (op),
		.operandA    (operandA),
		.operandB    (operandB),
		.accum       (accum),
		.hold        (hold),
		.result      (result),
		.resultValid (resultValid),
		.divFast     (divFast)
	);

	always #5 clock = ~clock;

	task automatic addVector(input string name, input mulOp_t vOp, input word_t a,
		input word_t b, input dword_t acc, input dword_t expResult, input logic expFast);
		vecName[numVectors] = name;
		vecOp[numVectors] = vOp;
		vecA[numVectors] = a;
		vecB[numVectors] = b;
		vecAcc[numVectors] = acc;
		vecExp[numVectors] = expResult;
		vecFast[numVectors] = expFast;
		numVectors++;
	endtask

	task automatic loadVectors();
		addVector("s32 small", mulS32, 32'd5, 32'd7, 0, 64'd35, 0);
		addVector("s32 negative", mulS32, 32'hFFFFFFFB, 32'd7, 0, 64'hFFFFFFFF_FFFFFFDD, 0);
		addVector("s32 low wraps", mulS32, 32'h00010000, 32'h00010000, 0, 64'd0, 0);
		addVector("s32 sign of low", mulS32, 32'h00008000, 32'h00010000, 0,
			64'hFFFFFFFF_80000000, 0);
		addVector("u32 zero extend", mulU32, 32'h00008000, 32'h00010000, 0,
			64'h00000000_80000000, 0);
		addVector("u32 max by two", mulU32, 32'hFFFFFFFF, 32'd2, 0, 64'h00000000_FFFFFFFE, 0);
		// accumulator must be ignored outside the MAC
		addVector("s64 min squared", mulS64, 32'h80000000, 32'h80000000, 64'h1234,
			64'h40000000_00000000, 0);
		addVector("u64 max squared", mulU64, 32'hFFFFFFFF, 32'hFFFFFFFF, 0,
			64'hFFFFFFFE_00000001, 0);
		addVector("s64 minus one sq", mulS64, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 64'd1, 0);
		addVector("s64 min by -1", mulS64, 32'h80000000, 32'hFFFFFFFF, 0,
			64'h00000000_80000000, 0);
		addVector("u64 min by max", mulU64, 32'h80000000, 32'hFFFFFFFF, 0,
			64'h7FFFFFFF_80000000, 0);
		addVector("s64 min by max", mulS64, 32'h80000000, 32'h7FFFFFFF, 0,
			64'hC0000000_80000000, 0);
		addVector("u64 nibble shift", mulU64, 32'h12345678, 32'h10, 0, 64'h00000001_23456780, 0);
		addVector("s64 minus two", mulS64, 32'hFFFFFFFE, 32'h12345678, 0,
			64'hFFFFFFFF_DB975310, 0);
		addVector("mac small", macS64, 32'd3, 32'd4, 64'd10, 64'd22, 0);
		addVector("mac minus one", macS64, 32'hFFFFFFFF, 32'd1, 0, 64'hFFFFFFFF_FFFFFFFF, 0);
		addVector("mac wraps", macS64, 32'h80000000, 32'h80000000, 64'hC0000000_00000000,
			64'd0, 0);
		addVector("mac carry", macS64, 32'h00010000, 32'h00010000, 64'hFFFFFFFF_FFFFFFFF,
			64'h00000000_FFFFFFFF, 0);
		addVector("div by 7", divU, 32'd100, 32'd7, 0, 64'd14, 1);
		addVector("div by 3", divS, 32'd1000000, 32'd3, 0, 64'd333333, 1);
		addVector("div max by 63", divU, 32'h3FFFFFFF, 32'd63, 0, 64'd17043521, 1);
		addVector("div max by 2", divU, 32'h3FFFFFFF, 32'd2, 0, 64'd536870911, 1);
		addVector("div by 10", divS, 32'd12345, 32'd10, 0, 64'd1234, 1);
		addVector("div by 32", divU, 32'd999, 32'd32, 0, 64'd31, 1);
		addVector("div by 48", divU, 32'd1000000, 32'd48, 0, 64'd20833, 1);
		addVector("div by 9", divS, 32'd81, 32'd9, 64'd5, 64'd9, 1);
		// the fast path turns these away
		addVector("div by 0", divU, 32'd1000, 32'd0, 0, 64'd0, 0);
		addVector("div by 1", divS, 32'd1000, 32'd1, 0, 64'd0, 0);
		addVector("div by 64", divU, 32'd1000, 32'd64, 0, 64'd0, 0);
		addVector("div big dividend", divS, 32'h40000000, 32'd5, 0, 64'd0, 0);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic abortRun();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkResult(input string name, input dword_t expected, input dword_t actual);
		if (actual !== expected) begin
			$display("Fail %s: result expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s: divFast expected %b, actual %b", name, expected, actual);
			abortRun();
		end
	endtask

	// take a result when the output register is free to advance
	always @(negedge clock) begin : resultCheck
		int idx;
		if (!reset && resultValid === 1'b1 && hold === 1'b0) begin
			if (pending.size() == 0) begin
				$display("resultValid came with no operation outstanding");
				abortRun();
			end else begin
				idx = pending.pop_front();
				checkResult(vecName[idx], vecExp[idx], result);
				checkFlag(vecName[idx], vecFast[idx], divFast);
			end
		end
	end

	// stop as soon as the bound checker sees a pipeline fault
	always @(negedge clock) begin
		if (dut0.chk0.failCount != 0) begin
			$display("A pipeline assertion in the bound checker failed");
			abortRun();
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycleCount++;
			if (cycleCount > cycleLimit) begin
				$display("Timeout: %0d results still missing", pending.size());
				abortRun();
			end
		end
	end

	initial begin
		int vecIndex;
		logic holdNow;
		clock = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		op = mulS32;
		operandA = '0;
		operandB = '0;
		accum = '0;
		hold = 1'b0;
		loadVectors();
		cycleLimit = numVectors * 8 + 64;
		vecIndex = 0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		// idle after reset so a stray resultValid gets caught
		repeat (4) @(posedge clock);
		while (vecIndex < numVectors || pending.size() > 0) begin
			@(posedge clock);
			lfsrState = stepLfsr(lfsrState);
			holdNow = lfsrState[0];
			hold <= holdNow;
			if (!holdNow && vecIndex < numVectors) begin
				issue <= 1'b1;
				op <= vecOp[vecIndex];
				operandA <= vecA[vecIndex];
				operandB <= vecB[vecIndex];
				accum <= vecAcc[vecIndex];
				pending.push_back(vecIndex);
				vecIndex++;
			end else begin
				issue <= 1'b0;
			end
		end
		@(posedge clock);
		hold <= 1'b0;
		issue <= 1'b0;
		repeat (6) @(posedge clock);
		if (dut0.chk0.failCount == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d pipeline assertions failed", dut0.chk0.failCount);
			abortRun();
		end
	end

endmodule

/* flist.f */
+incdir+source
source/mulDataPkg.sv
source/mulCmdPkg.sv
source/mulOperandPrep.sv
source/mulPartialArray.sv
source/mulResultShaper.sv
source/mulUnit.sv
test/mulUnit_chk.sv
test/mulUnitTb.sv
